/* logic/fetch_pkg.sv */
package fetch_pkg;

    // datapath and address widths
    localparam int XLEN = 32;
    // sv32 physical address is 34 bits
    localparam int PA_LEN = 34;
    localparam int PAGE_SHIFT = 12;
    localparam int PTE_BYTES = 4;

    // pte permission bits
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;

    // trap vector layout
    localparam int TRAP_LEN = 3;
    localparam int TRAP_INST_ADDR_MISALIGNED = 0;
    localparam int TRAP_INST_ACCESS_FAULT = 1;
    localparam int TRAP_INST_PAGE_FAULT = 2;

    // paging config from csr side
    typedef struct packed {
        logic        en;
        logic [21:0] root_ppn;
    } satp_cfg_t;

    // decoded fetch handed to the engine
    typedef struct packed {
        logic [XLEN-1:0] vaddr;
        logic            translate;
    } fetch_cmd_t;

    // outcome of one engine run
    typedef enum logic [1:0] {
        ST_OK,
        ST_PAGE_FAULT,
        ST_ACCESS_FAULT
    } engine_status_e;

    typedef struct packed {
        engine_status_e    status;
        logic [XLEN-1:0]   inst;
        logic [PA_LEN-1:0] paddr;
    } engine_resp_t;

    // reply record toward the requester
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     inst;
        logic [TRAP_LEN-1:0] trap;
    } fetch_rsp_t;

    // engine fsm, one state per memory step
    typedef enum logic [2:0] {
        W_IDLE,
        W_PTE1,
        W_PTE0,
        W_INST,
        W_DONE
    } walk_state_e;

    // controller fsm
    typedef enum logic [1:0] {
        C_IDLE,
        C_RUN,
        C_HOLD
    } ctrl_state_e;

endpackage

/* logic/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_req_i,
    input  logic [31:0]             pc_i,
    input  logic                    satp_en_i,
    input  logic                    eng_ack_i,
    input  fetch_pkg::engine_resp_t eng_resp_i,
    output logic                    fetch_ack_o,
    output logic                    eng_req_o,
    output fetch_pkg::fetch_cmd_t   eng_cmd_o,
    output logic                    rsp_load_o,
    output logic                    misaligned_o
);
    import fetch_pkg::*;

    ctrl_state_e state;
    // pc of the accepted fetch was not word aligned
    logic mis_q;
    logic accept;
    logic pc_mis;
    logic run_done;

    // new fetch only from idle
    assign accept = (state == C_IDLE) && fetch_req_i;
    assign pc_mis = |pc_i[1:0];

    // misaligned fetch finishes without the engine
    assign run_done = (state == C_RUN) && (mis_q || eng_ack_i);
    assign rsp_load_o = run_done;

    assign misaligned_o = mis_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= C_IDLE;
            mis_q <= 1'b0;
            fetch_ack_o <= 1'b0;
            eng_req_o <= 1'b0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (accept) begin
                        mis_q <= pc_mis;
                        // engine request one cycle after accept
                        eng_req_o <= !pc_mis;
                        state <= C_RUN;
                    end
                end
                C_RUN: begin
                    if (run_done) begin
                        eng_req_o <= 1'b0;
                        fetch_ack_o <= 1'b1;
                        state <= C_HOLD;
                    end
                end
                C_HOLD: begin
                    // ack follows req down one cycle later
                    if (!fetch_req_i) begin
                        fetch_ack_o <= 1'b0;
                        // engine handshake must be closed too
                        if (!eng_ack_i) begin
                            state <= C_IDLE;
                        end
                    end
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    // command captured with satp enable sampled at accept
    always_ff @(posedge clk) begin
        if (accept) begin
            eng_cmd_o.vaddr <= pc_i;
            eng_cmd_o.translate <= satp_en_i;
        end
    end

endmodule

/* logic/fetch_engine.sv */
`timescale 1ns/1ps

module fetch_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    eng_req_i,
    input  fetch_pkg::fetch_cmd_t   eng_cmd_i,
    input  logic [21:0]             root_ppn_i,
    input  logic                    mem_ack_i,
    input  logic [31:0]             mem_rdata_i,
    output logic                    eng_ack_o,
    output fetch_pkg::engine_resp_t eng_resp_o,
    output logic                    mem_req_o,
    output logic [31:0]             mem_addr_o
);
    import fetch_pkg::*;

    walk_state_e state;
    walk_state_e next_st;
    engine_resp_t resp_q;
    // last word read, pte or instruction
    logic [XLEN-1:0] rdata_q;
    // data captured, waiting for mem ack to drop
    logic got_q;

    logic [9:0] vpn1;
    logic [9:0] vpn0;
    logic [11:0] pg_off;
    logic [PA_LEN-1:0] l1_addr;
    logic [PA_LEN-1:0] l0_addr;
    logic [PA_LEN-1:0] mega_paddr;
    logic [PA_LEN-1:0] page_paddr;
    logic [PA_LEN-1:0] next_addr;
    logic pte_bad;
    logic pte_leaf;
    logic start;
    logic step;
    logic capture;
    logic eval;
    logic walk_pf;
    logic walk_ok;
    logic addr_af;
    logic issue;
    logic finish;

    assign vpn1 = eng_cmd_i.vaddr[31:22];
    assign vpn0 = eng_cmd_i.vaddr[21:12];
    assign pg_off = eng_cmd_i.vaddr[11:0];

    // pte address per level
    assign l1_addr = (PA_LEN'(root_ppn_i) << PAGE_SHIFT) + PA_LEN'(vpn1) * PA_LEN'(PTE_BYTES);
    assign l0_addr = (PA_LEN'(rdata_q[31:10]) << PAGE_SHIFT) + PA_LEN'(vpn0) * PA_LEN'(PTE_BYTES);
    // megapage keeps vpn0 from the vaddr
    assign mega_paddr = {rdata_q[31:20], vpn0, pg_off};
    assign page_paddr = {rdata_q[31:10], pg_off};

    // reserved w without r counts as invalid
    assign pte_bad = !rdata_q[PTE_V] || (rdata_q[PTE_W] && !rdata_q[PTE_R]);
    assign pte_leaf = rdata_q[PTE_R] || rdata_q[PTE_X];

    // handshake phases of the memory port
    assign start = (state == W_IDLE) && eng_req_i && !mem_ack_i;
    assign capture = mem_req_o && mem_ack_i;
    assign step = got_q && !mem_ack_i;
    assign eval = start || step;

    // decide the next memory step
    always_comb begin
        walk_pf = 1'b0;
        walk_ok = 1'b0;
        next_addr = '0;
        next_st = W_IDLE;
        case (state)
            W_IDLE: begin
                if (eng_cmd_i.translate) begin
                    next_addr = l1_addr;
                    next_st = W_PTE1;
                end else begin
                    next_addr = PA_LEN'(eng_cmd_i.vaddr);
                    next_st = W_INST;
                end
            end
            W_PTE1: begin
                if (pte_bad) begin
                    walk_pf = 1'b1;
                end else if (pte_leaf) begin
                    // megapage needs x and a zero ppn0
                    walk_pf = !rdata_q[PTE_X] || (|rdata_q[19:10]);
                    next_addr = mega_paddr;
                    next_st = W_INST;
                end else begin
                    next_addr = l0_addr;
                    next_st = W_PTE0;
                end
            end
            W_PTE0: begin
                // pointer at level 0 is a fault
                walk_pf = pte_bad || !pte_leaf || !rdata_q[PTE_X];
                next_addr = page_paddr;
                next_st = W_INST;
            end
            W_INST: begin
                walk_ok = 1'b1;
            end
            default: begin
                walk_ok = 1'b0;
            end
        endcase
    end

    // address above 4 GiB is never put on the port
    assign addr_af = |next_addr[PA_LEN-1:XLEN];
    assign issue = eval && !walk_pf && !walk_ok && !addr_af;
    assign finish = eval && !issue;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= W_IDLE;
            mem_req_o <= 1'b0;
            got_q <= 1'b0;
            eng_ack_o <= 1'b0;
        end else begin
            if (capture) begin
                mem_req_o <= 1'b0;
                got_q <= 1'b1;
            end
            if (step) begin
                got_q <= 1'b0;
            end
            if (issue) begin
                mem_req_o <= 1'b1;
                state <= next_st;
            end
            if (finish) begin
                eng_ack_o <= 1'b1;
                state <= W_DONE;
            end
            // close the engine handshake
            if ((state == W_DONE) && !eng_req_i) begin
                eng_ack_o <= 1'b0;
                state <= W_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= mem_rdata_i;
        end
        if (issue) begin
            mem_addr_o <= next_addr[XLEN-1:0];
        end
        if (eval && !walk_pf && !walk_ok) begin
            resp_q.paddr <= next_addr;
        end
        if (finish) begin
            resp_q.status <= walk_pf ? ST_PAGE_FAULT : (walk_ok ? ST_OK : ST_ACCESS_FAULT);
            resp_q.inst <= walk_ok ? rdata_q : '0;
        end
    end

    assign eng_resp_o = resp_q;

endmodule

/* logic/fetch_result.sv */
`timescale 1ns/1ps

module fetch_result (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rsp_load_i,
    input  logic                    misaligned_i,
    input  logic [31:0]             pc_i,
    input  fetch_pkg::engine_resp_t eng_resp_i,
    output fetch_pkg::fetch_rsp_t   fetch_rsp_o
);
    import fetch_pkg::*;

    logic [TRAP_LEN-1:0] trap;
    fetch_rsp_t rsp_q;

    // misaligned masks any engine status
    always_comb begin
        trap = '0;
        trap[TRAP_INST_ADDR_MISALIGNED] = misaligned_i;
        trap[TRAP_INST_ACCESS_FAULT] = !misaligned_i && (eng_resp_i.status == ST_ACCESS_FAULT);
        trap[TRAP_INST_PAGE_FAULT] = !misaligned_i && (eng_resp_i.status == ST_PAGE_FAULT);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_q <= '0;
        end else if (rsp_load_i) begin
            rsp_q.pc <= pc_i;
            // no instruction word on a trapped fetch
            rsp_q.inst <= (|trap) ? '0 : eng_resp_i.inst;
            rsp_q.trap <= trap;
        end
    end

    // visible from the cycle after the load
    assign fetch_rsp_o = rsp_q;

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_req_i,
    input  logic [31:0]           pc_i,
    input  fetch_pkg::satp_cfg_t  satp_i,
    input  logic                  mem_ack_i,
    input  logic [31:0]           mem_rdata_i,
    output logic                  fetch_ack_o,
    output fetch_pkg::fetch_rsp_t fetch_rsp_o,
    output logic                  mem_req_o,
    output logic [31:0]           mem_addr_o
);
    import fetch_pkg::*;

    // ctrl to engine handshake
    logic eng_req;
    logic eng_ack;
    fetch_cmd_t eng_cmd;
    engine_resp_t eng_resp;
    // ctrl to result load strobe
    logic rsp_load;
    logic misaligned;

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .fetch_req_i  (fetch_req_i),
        .pc_i         (pc_i),
        .satp_en_i    (satp_i.en),
        .eng_ack_i    (eng_ack),
        .eng_resp_i   (eng_resp),
        .fetch_ack_o  (fetch_ack_o),
        .eng_req_o    (eng_req),
        .eng_cmd_o    (eng_cmd),
        .rsp_load_o   (rsp_load),
        .misaligned_o (misaligned)
    );

    fetch_engine u_engine (
        .clk         (clk),
        .rst         (rst),
        .eng_req_i   (eng_req),
        .eng_cmd_i   (eng_cmd),
        .root_ppn_i  (satp_i.root_ppn),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .eng_ack_o   (eng_ack),
        .eng_resp_o  (eng_resp),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o)
    );

    // pc comes from the accepted command
    fetch_result u_result (
        .clk          (clk),
        .rst          (rst),
        .rsp_load_i   (rsp_load),
        .misaligned_i (misaligned),
        .pc_i         (eng_cmd.vaddr),
        .eng_resp_i   (eng_resp),
        .fetch_rsp_o  (fetch_rsp_o)
    );

endmodule

/* verification/fetch_mem_model.sv */
`timescale 1ns/1ps

module fetch_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req_i,
    input  logic [31:0] mem_addr_i,
    output logic        mem_ack_o,
    output logic [31:0] mem_rdata_o
);
    // root table at 0x10000, level-0 table at 0x11000
    logic [31:0] pt [0:2047];
    integer seed = 71;
    int lat;
    // cycles left before ack
    int wait_cnt;
    logic busy;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (addr[31:13] == 19'd8) begin
            return pt[addr[12:2]];
        end
        // code words hold their own address
        return addr;
    endfunction

    initial begin
        for (int i = 0; i < 2048; i++) begin
            pt[i] = 32'h0;
        end
        // root: megapage at 0x00800000
        pt[1] = 32'h0020_000b;
        // root: megapage with nonzero ppn0
        pt[2] = 32'h0020_040b;
        // root: pointer to level-0 table
        pt[3] = 32'h0000_4401;
        // root: w without r, reserved
        pt[5] = 32'h0000_0005;
        // level 0: executable leaf, ppn 0x123
        pt[1024] = 32'h0004_8c0b;
        // level 0: read only leaf
        pt[1025] = 32'h0004_9003;
        // level 0: ppn above 4 GiB
        pt[1026] = 32'h4004_940b;
    end

    // four-phase slave, 0 to 3 extra cycles before ack
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ack_o <= 1'b0;
            mem_rdata_o <= 32'h0;
            busy <= 1'b0;
            wait_cnt <= 0;
        end else if (!mem_req_i) begin
            mem_ack_o <= 1'b0;
            busy <= 1'b0;
        end else if (!mem_ack_o) begin
            if (!busy) begin
                lat = $random(seed) & 3;
                if (lat == 0) begin
                    mem_ack_o <= 1'b1;
                    mem_rdata_o <= read_word(mem_addr_i);
                end else begin
                    busy <= 1'b1;
                    wait_cnt <= lat - 1;
                end
            end else if (wait_cnt == 0) begin
                mem_ack_o <= 1'b1;
                mem_rdata_o <= read_word(mem_addr_i);
                busy <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

/* verification/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    logic clk;
    logic rst;
    logic fetch_req;
    logic [31:0] pc;
    satp_cfg_t satp;
    logic mem_ack;
    logic [31:0] mem_rdata;
    logic fetch_ack;
    fetch_rsp_t fetch_rsp;
    logic mem_req;
    logic [31:0] mem_addr;

    // own copy of the page tables
    logic [31:0] ref_pt [0:2047];
    integer seed;
    int errors;
    int checks;
    // handshake monitor state
    int mon_errors = 0;
    int req_rises = 0;
    logic req_prev = 1'b0;
    logic ack_prev = 1'b0;
    satp_cfg_t bare;
    satp_cfg_t sv32;
    logic [31:0] rnd_pc;

    fetch_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .fetch_req_i (fetch_req),
        .pc_i        (pc),
        .satp_i      (satp),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata),
        .fetch_ack_o (fetch_ack),
        .fetch_rsp_o (fetch_rsp),
        .mem_req_o   (mem_req),
        .mem_addr_o  (mem_addr)
    );

    fetch_mem_model mem0 (
        .clk         (clk),
        .rst         (rst),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // handshake rules, sampled mid cycle
    always @(negedge clk) begin
        if (mem_req && !req_prev) begin
            req_rises++;
            assert (!mem_ack)
                else begin
                    $display("mem_req_o rose while mem_ack_i was still high");
                    mon_errors++;
                end
        end
        if (ack_prev && !fetch_ack) begin
            assert (!fetch_req)
                else begin
                    $display("fetch_ack_o fell while fetch_req_i was still high");
                    mon_errors++;
                end
        end
        req_prev = mem_req;
        ack_prev = fetch_ack;
    end

    function automatic logic [31:0] ref_word(input logic [33:0] addr);
        if (addr[33:13] == 21'd8) begin
            return ref_pt[addr[12:2]];
        end
        return addr[31:0];
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expv, input logic [31:0] actv);
        $display("** Error %s %s: expected %h, actual %h", test, what, expv, actv);
        errors++;
    endtask

    // sv32 walk on the copy, counts memory reads
    task automatic ref_translate(input logic [31:0] va, input satp_cfg_t cfg,
                                 output fetch_rsp_t exp, output int reads);
        logic [33:0] a;
        logic [33:0] pa;
        logic [31:0] pte;
        logic pf;
        logic af;
        pf = 1'b0;
        af = 1'b0;
        reads = 0;
        pa = {2'b00, va};
        exp.pc = va;
        exp.inst = '0;
        exp.trap = '0;
        if (va[1:0] != 2'b00) begin
            exp.trap[TRAP_INST_ADDR_MISALIGNED] = 1'b1;
        end else begin
            if (cfg.en) begin
                a = {cfg.root_ppn, 12'h000} + {22'h0, va[31:22], 2'b00};
                pte = ref_word(a);
                reads++;
                if (!pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R])) begin
                    pf = 1'b1;
                end else if (pte[PTE_R] || pte[PTE_X]) begin
                    // megapage leaf
                    pf = !pte[PTE_X] || (pte[19:10] != 10'h0);
                    pa = {pte[31:20], va[21:0]};
                end else begin
                    a = {pte[31:10], 12'h000} + {22'h0, va[21:12], 2'b00};
                    af = a[33:32] != 2'b00;
                    if (!af) begin
                        pte = ref_word(a);
                        reads++;
                        pf = !pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]) ||
                             !(pte[PTE_R] || pte[PTE_X]) || !pte[PTE_X];
                        pa = {pte[31:10], va[11:0]};
                    end
                end
            end
            if (!pf && !af && (pa[33:32] != 2'b00)) begin
                af = 1'b1;
            end
            if (pf) begin
                exp.trap[TRAP_INST_PAGE_FAULT] = 1'b1;
            end else if (af) begin
                exp.trap[TRAP_INST_ACCESS_FAULT] = 1'b1;
            end else begin
                exp.inst = ref_word(pa);
                reads++;
            end
        end
    endtask

    task automatic run_fetch(input string name, input logic [31:0] va, input satp_cfg_t cfg);
        fetch_rsp_t exp;
        int exp_reads;
        int rises_before;
        int cycles;
        ref_translate(va, cfg, exp, exp_reads);
        rises_before = req_rises;
        @(posedge clk);
        fetch_req <= 1'b1;
        pc <= va;
        satp <= cfg;
        cycles = 0;
        @(negedge clk);
        while (!fetch_ack && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!fetch_ack) begin
            $display("%s: fetch_ack_o did not rise within 200 cycles", name);
            errors++;
        end else begin
            checks++;
            assert (fetch_rsp.pc == exp.pc)
                else report_mismatch(name, "pc", exp.pc, fetch_rsp.pc);
            assert (fetch_rsp.inst == exp.inst)
                else report_mismatch(name, "inst", exp.inst, fetch_rsp.inst);
            assert (fetch_rsp.trap == exp.trap)
                else report_mismatch(name, "trap", 32'(exp.trap), 32'(fetch_rsp.trap));
            assert (req_rises - rises_before == exp_reads)
                else report_mismatch(name, "mem reads", exp_reads, req_rises - rises_before);
            // misaligned pc never starts the engine
            if (exp.trap[TRAP_INST_ADDR_MISALIGNED]) begin
                assert (cycles == 2)
                    else report_mismatch(name, "ack latency", 2, cycles);
            end
        end
        @(posedge clk);
        fetch_req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (fetch_ack && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (fetch_ack) begin
            $display("%s: fetch_ack_o stayed high after fetch_req_i fell", name);
            errors++;
        end
    endtask

    initial begin
        rst = 1'b1;
        fetch_req = 1'b0;
        pc = 32'h0;
        satp = '0;
        seed = 71;
        errors = 0;
        checks = 0;
        for (int i = 0; i < 2048; i++) begin
            ref_pt[i] = 32'h0;
        end
        ref_pt[1] = 32'h0020_000b;
        ref_pt[2] = 32'h0020_040b;
        ref_pt[3] = 32'h0000_4401;
        ref_pt[5] = 32'h0000_0005;
        ref_pt[1024] = 32'h0004_8c0b;
        ref_pt[1025] = 32'h0004_9003;
        ref_pt[1026] = 32'h4004_940b;
        bare = '0;
        sv32.en = 1'b1;
        sv32.root_ppn = 22'h10;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        run_fetch("bare_low", 32'h0000_1000, bare);
        run_fetch("bare_high", 32'hffff_fffc, bare);
        // bare read of a table word
        run_fetch("bare_table", 32'h0001_1004, bare);
        for (int i = 0; i < 4; i++) begin
            rnd_pc = $random(seed) & 32'hffff_fffc;
            run_fetch("bare_random", rnd_pc, bare);
        end
        run_fetch("misaligned_bare", 32'h0000_1002, bare);
        run_fetch("misaligned_sv32", 32'h00c0_0011, sv32);
        run_fetch("sv32_page", 32'h00c0_0010, sv32);
        run_fetch("sv32_page_end", 32'h00c0_0ffc, sv32);
        run_fetch("sv32_mega", 32'h0040_5a34, sv32);
        run_fetch("sv32_mega_misaligned", 32'h0080_0100, sv32);
        run_fetch("sv32_invalid_root", 32'h0100_0000, sv32);
        run_fetch("sv32_reserved_wr", 32'h0140_0000, sv32);
        run_fetch("sv32_no_exec", 32'h00c0_1000, sv32);
        run_fetch("sv32_invalid_leaf", 32'h00c0_3000, sv32);
        run_fetch("sv32_above_4g", 32'h00c0_2008, sv32);

        errors = errors + mon_errors;
        $display("errors: %0d, fetches checked: %0d", errors, checks);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* src.f */
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/fetch_engine.sv
logic/fetch_result.sv
logic/fetch_top.sv
verification/fetch_mem_model.sv
verification/tb_fetch_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fetch testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_fetch_top \
    -Mdir obj_dir -o sim_fetch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_fetch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi
